// ==== Bender.yml ====
package:
  name: lcd_greeting

sources:
  - include_dirs:
      - include
    files:
      - hdl/lcd_pkg.sv
      - hdl/lcd_req_if.sv
      - hdl/lcd_bus_cycle.sv
      - hdl/lcd_ctrl.sv
      - hdl/lcd_msg_seq.sv
      - hdl/pb_debounce.sv
      - hdl/lcd_top.sv
  - target: test
    files:
      - sim/tb_lcd_top.sv

// ==== build.f ====
+incdir+include
hdl/lcd_pkg.sv
hdl/lcd_req_if.sv
hdl/lcd_bus_cycle.sv
hdl/lcd_ctrl.sv
hdl/lcd_msg_seq.sv
hdl/pb_debounce.sv
hdl/lcd_top.sv
sim/tb_lcd_top.sv

// ==== hdl/lcd_bus_cycle.sv ====
// one timed write on the LCD pins: setup, E pulse, then execution wait
// started by a one-cycle strobe, finished pulses once the wait is over
`timescale 1ns/1ps

module lcd_bus_cycle (
	input logic CLK,
	input logic lcdreset,
	input logic start,
	input logic rs_in,
	input lcd_pkg::lcd_byte_t data_in,
	input int wait_cycles,
	output logic finished,
	output logic lcd_rs,
	output logic lcd_e,
	output lcd_pkg::lcd_byte_t lcd_d
);
	import lcd_pkg::*;

	bus_state_t state;
	int cnt;
	int wait_q;

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			state <= bs_idle;
			cnt <= 0;
			finished <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_e <= 1'b0;
			lcd_d <= '0;
		end else begin
			finished <= 1'b0;
			case (state)
				bs_idle: begin
					if (start) begin
						lcd_rs <= rs_in;
						lcd_d <= data_in;
						wait_q <= wait_cycles;
						cnt <= T_AS - 1;
						state <= bs_setup;
					end
				end
				// rs and data settle with E low
				bs_setup: begin
					if (cnt == 0) begin
						lcd_e <= 1'b1;
						cnt <= T_PW - 1;
						state <= bs_pulse;
					end else begin
						cnt <= cnt - 1;
					end
				end
				bs_pulse: begin
					if (cnt == 0) begin
						lcd_e <= 1'b0;
						cnt <= wait_q - 1;
						state <= bs_wait;
					end else begin
						cnt <= cnt - 1;
					end
				end
				// display executes, pins stay put
				bs_wait: begin
					if (cnt == 0) begin
						finished <= 1'b1;
						state <= bs_idle;
					end else begin
						cnt <= cnt - 1;
					end
				end
				default: state <= bs_idle;
			endcase
		end
	end

	// E only ever high inside the pulse window
	a_e_low_outside_pulse: assert property (
		@(posedge CLK) disable iff (lcdreset)
		(state == bs_idle || state == bs_wait) |-> !lcd_e
	);

endmodule

// ==== hdl/lcd_ctrl.sv ====
// turns each requested LCD operation into its sequence of bus writes
// done pulses one cycle after the last write has finished
`timescale 1ns/1ps

module lcd_ctrl (
	input logic CLK,
	input logic lcdreset,
	lcd_req_if.ctrl req_port,
	output logic lcd_rs,
	output logic lcd_e,
	output lcd_pkg::lcd_byte_t lcd_d
);
	import lcd_pkg::*;

	ctrl_state_t state;
	lcd_op_t op_q;
	lcd_byte_t arg_q;
	logic [INIT_IDX_W-1:0] idx;

	logic start;
	logic finished;
	logic wr_rs;
	lcd_byte_t wr_data;
	int wr_wait;
	logic last_wr;

	////////////////////////////////////////
	// operation to bus write mapping

	always_comb begin
		wr_rs = 1'b0;
		wr_data = arg_q;
		wr_wait = T_EXEC;
		last_wr = 1'b1;
		case (op_q)
			op_init: begin
				wr_data = INIT_SEQ[idx];
				wr_wait = T_PWRUP;
				last_wr = (idx == INIT_IDX_W'(INIT_LEN - 1));
			end
			op_clear: begin
				wr_data = 8'h01;
				wr_wait = T_CLR;
			end
			// set DD RAM address
			op_addr: wr_data = 8'h80 | arg_q;
			op_data: wr_rs = 1'b1;
			default: wr_rs = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// one write at a time

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			state <= cs_idle;
			idx <= '0;
		end else begin
			case (state)
				cs_idle: begin
					if (req_port.req) begin
						op_q <= req_port.op;
						arg_q <= req_port.arg;
						idx <= '0;
						state <= cs_issue;
					end
				end
				cs_issue: state <= cs_busy;
				cs_busy: begin
					if (finished) begin
						if (last_wr) begin
							state <= cs_done;
						end else begin
							idx <= idx + 1'b1;
							state <= cs_issue;
						end
					end
				end
				cs_done: state <= cs_idle;
				default: state <= cs_idle;
			endcase
		end
	end

	assign start = (state == cs_issue);
	assign req_port.done = (state == cs_done);

	lcd_bus_cycle u_bus (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.start(start),
		.rs_in(wr_rs),
		.data_in(wr_data),
		.wait_cycles(wr_wait),
		.finished(finished),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e),
		.lcd_d(lcd_d)
	);

	// the sequencer must wait for done before the next request
	a_no_req_while_busy: assert property (
		@(posedge CLK) disable iff (lcdreset)
		req_port.req |-> (state == cs_idle)
	);

endmodule

// ==== hdl/lcd_msg_seq.sv ====
// start-up and greeting sequencer for init, clear, address and then the text
// a restart sends it back to the start once any outstanding request completes
`timescale 1ns/1ps

module lcd_msg_seq (
	input logic CLK,
	input logic lcdreset,
	input logic restart,
	lcd_req_if.seq req_port,
	output logic msg_done
);
	import lcd_pkg::*;

	seq_state_t state;
	logic pend;
	// restart seen while a request was outstanding
	logic restart_seen;
	logic [MSG_IDX_W-1:0] idx;

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			state <= sq_init;
			pend <= 1'b0;
			restart_seen <= 1'b0;
			idx <= MSG_IDX_W'(MSG_LEN - 1);
			req_port.req <= 1'b0;
			msg_done <= 1'b0;
		end else begin
			req_port.req <= 1'b0;
			if (restart)
				msg_done <= 1'b0;

			if (pend) begin
				// let the outstanding request complete
				if (req_port.done) begin
					pend <= 1'b0;
					restart_seen <= 1'b0;
					if (restart || restart_seen) begin
						state <= sq_init;
					end else begin
						case (state)
							sq_init: state <= sq_clear;
							sq_clear: state <= sq_addr;
							sq_addr: begin
								idx <= MSG_IDX_W'(MSG_LEN - 1);
								state <= sq_char;
							end
							sq_char: state <= sq_next;
							default: state <= sq_init;
						endcase
					end
				end else if (restart) begin
					restart_seen <= 1'b1;
				end
			end else if (restart) begin
				state <= sq_init;
			end else begin
				case (state)
					sq_init: begin
						req_port.req <= 1'b1;
						req_port.op <= op_init;
						req_port.arg <= '0;
						pend <= 1'b1;
					end
					sq_clear: begin
						req_port.req <= 1'b1;
						req_port.op <= op_clear;
						req_port.arg <= '0;
						pend <= 1'b1;
					end
					sq_addr: begin
						req_port.req <= 1'b1;
						req_port.op <= op_addr;
						req_port.arg <= MSG_ADDR;
						pend <= 1'b1;
					end
					// first character sits in the top byte
					sq_char: begin
						req_port.req <= 1'b1;
						req_port.op <= op_data;
						req_port.arg <= MSG_TEXT[idx*8 +: 8];
						pend <= 1'b1;
					end
					sq_next: begin
						if (idx == '0) begin
							state <= sq_stop;
						end else begin
							idx <= idx - 1'b1;
							state <= sq_char;
						end
					end
					sq_stop: msg_done <= 1'b1;
					default: state <= sq_init;
				endcase
			end
		end
	end

	// controller answers only what was asked
	a_done_only_when_pending: assert property (
		@(posedge CLK) disable iff (lcdreset)
		req_port.done |-> pend
	);

endmodule

// ==== hdl/lcd_pkg.sv ====
// shared types and timing for the 8-bit write-only character LCD driver
// timing values are in cycles of the clock supplied to lcd_top
package lcd_pkg;

`include "lcd_msg.svh"

	typedef logic [7:0] lcd_byte_t;

	typedef enum logic [1:0] {op_init, op_clear, op_addr, op_data} lcd_op_t;

	typedef enum logic [1:0] {bs_idle, bs_setup, bs_pulse, bs_wait} bus_state_t;

	typedef enum logic [1:0] {cs_idle, cs_issue, cs_busy, cs_done} ctrl_state_t;

	typedef enum logic [2:0] {
		sq_init, sq_clear, sq_addr, sq_char, sq_next, sq_stop
	} seq_state_t;

	////////////////////////////////////////
	// bus timing

	localparam int T_AS = 2;
	localparam int T_PW = 4;
	localparam int T_EXEC = 40;
	localparam int T_CLR = 1600;
	localparam int T_PWRUP = 4100;

	// restart button filter
	localparam int DEB_CYCLES = 16;

	////////////////////////////////////////
	// message and init data

	localparam int MSG_LEN = `LCD_MSG_LEN;
	localparam logic [8*MSG_LEN-1:0] MSG_TEXT = `LCD_MSG_TEXT;
	localparam lcd_byte_t MSG_ADDR = `LCD_MSG_ADDR;
	localparam int MSG_IDX_W = $clog2(MSG_LEN);

	// function set x3, display on, entry mode increment
	localparam int INIT_LEN = 5;
	localparam int INIT_IDX_W = $clog2(INIT_LEN);
	localparam lcd_byte_t INIT_SEQ [INIT_LEN] = '{8'h38, 8'h38, 8'h38, 8'h0C, 8'h06};

endpackage

// ==== hdl/lcd_req_if.sv ====
// request channel from the message sequencer to the LCD controller
// req is a one-cycle strobe, op and arg hold until done pulses
`timescale 1ns/1ps

interface lcd_req_if;
	import lcd_pkg::*;

	logic req;
	lcd_op_t op;
	lcd_byte_t arg;
	logic done;

	modport seq (
		output req,
		output op,
		output arg,
		input done
	);

	modport ctrl (
		input req,
		input op,
		input arg,
		output done
	);

endinterface

// ==== hdl/lcd_top.sv ====
// character LCD greeting, 8-bit write-only bus
// btn restarts the display sequence, msg_done marks a complete greeting
`timescale 1ns/1ps

module lcd_top (
	input logic CLK,
	input logic lcdreset,
	input logic btn,
	output logic [7:0] lcd_d,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic lcd_e,
	output logic msg_done
);

	logic restart;

	lcd_req_if req_bus ();

	pb_debounce u_debounce (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.btn(btn),
		.btn_db(restart)
	);

	lcd_msg_seq u_seq (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.restart(restart),
		.req_port(req_bus.seq),
		.msg_done(msg_done)
	);

	lcd_ctrl u_ctrl (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.req_port(req_bus.ctrl),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e),
		.lcd_d(lcd_d)
	);

	// write only
	assign lcd_rw = 1'b0;

endmodule

// ==== hdl/pb_debounce.sv ====
// push button filter: two-flop sync, then a stability counter
`timescale 1ns/1ps

module pb_debounce (
	input logic CLK,
	input logic lcdreset,
	input logic btn,
	output logic btn_db
);
	import lcd_pkg::*;

	logic sync_a;
	logic sync_b;
	int cnt;

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			sync_a <= 1'b0;
			sync_b <= 1'b0;
			cnt <= 0;
			btn_db <= 1'b0;
		end else begin
			sync_a <= btn;
			sync_b <= sync_a;
			// count only while the level differs from the output
			if (sync_b == btn_db) begin
				cnt <= 0;
			end else if (cnt == DEB_CYCLES - 1) begin
				btn_db <= sync_b;
				cnt <= 0;
			end else begin
				cnt <= cnt + 1;
			end
		end
	end

endmodule

// ==== include/lcd_msg.svh ====
// greeting shown on the character LCD after start-up or a restart
// pulled into lcd_pkg, which re-exports these values as localparams
`ifndef LCD_MSG_SVH
`define LCD_MSG_SVH

// number of characters in the greeting
`define LCD_MSG_LEN 11

// packed text, first character in the top byte
`define LCD_MSG_TEXT "hello world"

// DD RAM address of the first character
`define LCD_MSG_ADDR 8'h44

`endif

// ==== sim/tb_lcd_top.sv ====
// testbench for lcd_top with random button activity against a queue of expected LCD writes
// checks bus timing, write order and msg_done, then prints a count line and the verdict
`timescale 1ns/1ps

module tb_lcd_top;
	import lcd_pkg::*;

	// full sequences the timeout allows for
	localparam int RUNS = 6;

	logic CLK = 1'b0;
	logic lcdreset;
	logic btn;
	logic [7:0] lcd_d;
	logic lcd_rs;
	logic lcd_rw;
	logic lcd_e;
	logic msg_done;

	// expected writes with the oldest first
	logic exp_rs [$];
	lcd_byte_t exp_d [$];
	int exp_w [$];

	string test_name;
	int errors = 0;
	int checks = 0;
	int err_start;
	int cycles = 0;
	int cycle_limit;
	int wr_test;
	int exp_test;
	int unsigned lcg_state;

	// monitor and model debounce state
	logic prev_e;
	logic prev_rs;
	lcd_byte_t prev_d;
	logic rise_rs;
	lcd_byte_t rise_d;
	int same_cnt;
	int high_cnt;
	int low_cnt;
	int last_wait;
	logic rw_bad;
	logic mdl_db;
	int mdl_cnt;

	lcd_top dut_i (
		.CLK(CLK), .lcdreset(lcdreset), .btn(btn),
		.lcd_d(lcd_d), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_e(lcd_e),
		.msg_done(msg_done)
	);

	always #2 CLK = ~CLK;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(lcg_next() % (hi - lo + 1));
	endfunction

	function automatic int seq_cycles();
		int n;
		n = INIT_LEN * (T_AS + T_PW + T_PWRUP + 3);
		n += T_AS + T_PW + T_CLR + 3;
		n += (MSG_LEN + 1) * (T_AS + T_PW + T_EXEC + 3);
		return n;
	endfunction

	////////////////////////////////////////
	// compares and error lines

	task automatic check_byte(input string what, input lcd_byte_t exp, input lcd_byte_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s %s: expected %02h, actual %02h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s %s: expected %0b, actual %0b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR %s: %s", test_name, what);
	endtask

	////////////////////////////////////////
	// model of the write stream

	task automatic add_write(input logic rs, input lcd_byte_t d, input int w);
		exp_rs.push_back(rs);
		exp_d.push_back(d);
		exp_w.push_back(w);
		exp_test++;
	endtask

	// start-up, clear, address 44h, then the text
	task automatic fill_model();
		for (int i = 0; i < INIT_LEN; i++)
			add_write(1'b0, INIT_SEQ[i], T_PWRUP);
		add_write(1'b0, 8'h01, T_CLR);
		add_write(1'b0, 8'hC4, T_EXEC);
		for (int i = MSG_LEN - 1; i >= 0; i--)
			add_write(1'b1, MSG_TEXT[i*8 +: 8], T_EXEC);
	endtask

	task automatic flush_model();
		exp_test -= exp_d.size();
		exp_rs.delete();
		exp_d.delete();
		exp_w.delete();
	endtask

	task automatic record_write(input logic rs, input lcd_byte_t d);
		string what;
		what = $sformatf("write %0d", wr_test);
		wr_test++;
		if (exp_d.size() == 0) begin
			report_error($sformatf("unexpected E pulse, rs %0b data %02h", rs, d));
			last_wait = T_EXEC;
		end else begin
			check_bit({what, " rs"}, exp_rs.pop_front(), rs);
			check_byte({what, " data"}, exp_d.pop_front(), d);
			last_wait = exp_w.pop_front();
		end
	endtask

	// bus monitor samples away from the rising edge
	always @(negedge CLK) begin
		if (lcdreset) begin
			prev_e = 1'b0;
			prev_rs = 1'b0;
			prev_d = '0;
			same_cnt = 0;
			high_cnt = 0;
			low_cnt = 0;
			last_wait = 0;
			rw_bad = 1'b0;
			mdl_db = 1'b0;
			mdl_cnt = 0;
		end else begin
			// press registers after DEB_CYCLES samples at the new level
			if (btn === mdl_db) begin
				mdl_cnt = 0;
			end else begin
				mdl_cnt++;
				if (mdl_cnt == DEB_CYCLES) begin
					mdl_db = btn;
					mdl_cnt = 0;
					if (btn)
						flush_model();
					else
						fill_model();
				end
			end
			if (lcd_rw !== 1'b0 && !rw_bad) begin
				rw_bad = 1'b1;
				report_error("lcd_rw went high");
			end
			if (lcd_rs === prev_rs && lcd_d === prev_d)
				same_cnt++;
			else
				same_cnt = 0;
			if (lcd_e && !prev_e) begin
				if (same_cnt < T_AS)
					report_error($sformatf("rs/data valid only %0d cycles before E", same_cnt));
				if (low_cnt < last_wait)
					report_error($sformatf("E low %0d cycles, needs %0d", low_cnt, last_wait));
				rise_rs = lcd_rs;
				rise_d = lcd_d;
				high_cnt = 1;
			end else if (lcd_e || prev_e) begin
				if (lcd_rs !== rise_rs || lcd_d !== rise_d)
					report_error("rs/data moved while E was high");
				if (lcd_e) begin
					high_cnt++;
				end else begin
					check_count("E high cycles", T_PW, high_cnt);
					record_write(rise_rs, rise_d);
					low_cnt = 1;
				end
			end else begin
				low_cnt++;
				if (low_cnt <= last_wait && (lcd_rs !== rise_rs || lcd_d !== rise_d))
					report_error("rs/data moved during the execution wait");
			end
			prev_e = lcd_e;
			prev_rs = lcd_rs;
			prev_d = lcd_d;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus

	task automatic tick(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	task automatic press_button(input int len);
		btn = 1'b1;
		tick(len);
		btn = 1'b0;
	endtask

	// pulses too short for the debouncer
	task automatic glitch_burst(input int n);
		repeat (n) begin
			press_button(rand_range(1, DEB_CYCLES - 2));
			tick(rand_range(2, DEB_CYCLES));
		end
	endtask

	task automatic wait_msg_done();
		while (msg_done !== 1'b1)
			tick(1);
	endtask

	task automatic wait_writes(input int n);
		while (wr_test < n)
			tick(1);
	endtask

	task automatic restart_from_idle();
		press_button(rand_range(DEB_CYCLES + 2, 3 * DEB_CYCLES));
		// debounced level is still high here
		tick(4);
		check_bit("msg_done while held", 1'b0, msg_done);
	endtask

	// press that ends the last init write or the clear
	task automatic press_mid_run();
		int idx;
		int len;
		int w;
		idx = rand_range(INIT_LEN - 1, INIT_LEN);
		len = rand_range(DEB_CYCLES + 2, 3 * DEB_CYCLES);
		w = (idx == INIT_LEN) ? T_CLR : T_PWRUP;
		restart_from_idle();
		wait_writes(idx + 1);
		// centre the debounced press on the done of that operation
		tick(w - DEB_CYCLES - 1 - len / 2);
		press_button(len);
		wait_msg_done();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_start = errors;
		wr_test = 0;
		exp_test = 0;
	endtask

	// no E pulse may follow the greeting
	task automatic end_test();
		tick(4 * T_EXEC);
		check_bit("msg_done after greeting", 1'b1, msg_done);
		check_count("writes", exp_test, wr_test);
		check_count("writes left in model", 0, exp_d.size());
		$display("test %s: %0d writes, %0d errors", test_name, wr_test, errors - err_start);
	endtask

	initial begin
		lcg_state = 74;
		cycle_limit = RUNS * seq_cycles() * 2;
		btn = 1'b0;
		lcdreset = 1'b1;
		begin_test("boot");
		fill_model();
		repeat (5) @(posedge CLK);
		#1;
		lcdreset = 1'b0;
		wait_msg_done();
		end_test();

		begin_test("glitch_idle");
		glitch_burst(10);
		end_test();

		begin_test("press_idle");
		restart_from_idle();
		tick(2 * DEB_CYCLES);
		glitch_burst(rand_range(4, 12));
		wait_msg_done();
		end_test();

		for (int k = 0; k < 2; k++) begin
			begin_test($sformatf("press_mid_%0d", k));
			press_mid_run();
			end_test();
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
